//--- common/i3c_cfg.svh
// Bus monitor sizing; I3C_ADDR_BITS + 1 must equal I3C_BYTE_BITS for the address view to fit
`ifndef I3C_CFG_SVH
`define I3C_CFG_SVH

// Synchronizer flops on each bus pin, at least 2
`define I3C_SYNC_STAGES 2

// Data bits in one bus byte
`define I3C_BYTE_BITS 8

// Data bits plus the ACK/T bit that closes a frame
`define I3C_BITS_PER_FRAME 9

// Static or dynamic target address width
`define I3C_ADDR_BITS 7

// The RnW bit takes the byte's LSB after the address,
// so the address view of a byte is
//   [I3C_BYTE_BITS-1:1] address
//   [0]                 RnW
// and the first byte after START is always read through it.
// Bytes after that keep the raw view.

`endif

//--- common/i3c_bus_pkg.sv
// Bus-level types only; edge flags and strobes are valid for exactly one clk_i cycle
`default_nettype none

package i3c_bus_pkg;

  // Synchronized scl/sda levels and their edge flags
  // An edge flag is high in the first cycle the new level is visible
  typedef struct packed {
    logic scl;
    logic sda;
    logic scl_rise;
    logic scl_fall;
    logic sda_rise;
    logic sda_fall;
  } bus_sample_t;

  // Bus conditions seen on the wires
  // START: sda falls while scl is high (also a repeated START)
  // STOP:  sda rises while scl is high
  typedef struct packed {
    logic start;
    logic stop;
  } bus_event_t;

endpackage

`default_nettype wire

//--- common/i3c_frame_pkg.sv
// Framing types; one received byte is read either as address+RnW or as raw data
`default_nettype none

package i3c_frame_pkg;

  `include "i3c_cfg.svh"

  // Address byte as it arrives after START, address MSB first
  typedef struct packed {
    logic [`I3C_ADDR_BITS-1:0] addr;
    logic                      rnw;
  } rx_addr_t;

  // Same received byte in both views
  // Which view is valid depends only on the framing state
  typedef union packed {
    logic [`I3C_BYTE_BITS-1:0] raw;
    rx_addr_t                  addr;
  } rx_byte_u;

  // Framing state of the monitor
  //   IDLE  no transfer open, bytes are dropped
  //   ADDR  START seen, next byte is the address
  //   DATA  address taken, bytes are payload
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ADDR = 2'd1,
    DATA = 2'd2
  } frame_state_e;

endpackage

`default_nettype wire

//--- design/i3c_phy.sv
// Receive-only pin front end; glitch filtering and bus driving are not provided
`timescale 1ns/1ps
`default_nettype none

`include "i3c_cfg.svh"

module i3c_phy
  import i3c_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        scl_i,
  input  logic        sda_i,
  output bus_sample_t bus_o
);

  localparam int unsigned sync_stages = `I3C_SYNC_STAGES;

  // Synchronizer chains, stage 0 samples the pin
  logic [sync_stages-1:0] scl_sync;
  logic [sync_stages-1:0] sda_sync;

  // Levels seen one cycle earlier
  logic scl_prev;
  logic sda_prev;

  logic scl_lvl;
  logic sda_lvl;

  // Released bus out of reset, so no false edges follow it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_sync <= '1;
      sda_sync <= '1;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[sync_stages-2:0], scl_i};
      sda_sync <= {sda_sync[sync_stages-2:0], sda_i};
      scl_prev <= scl_lvl;
      sda_prev <= sda_lvl;
    end
  end

  assign scl_lvl = scl_sync[sync_stages-1];
  assign sda_lvl = sda_sync[sync_stages-1];

  // Edge flags from current vs previous level
  always_comb begin
    bus_o.scl      = scl_lvl;
    bus_o.sda      = sda_lvl;
    bus_o.scl_rise = scl_lvl & ~scl_prev;
    bus_o.scl_fall = ~scl_lvl & scl_prev;
    bus_o.sda_rise = sda_lvl & ~sda_prev;
    bus_o.sda_fall = ~sda_lvl & sda_prev;
  end

endmodule

`default_nettype wire

//--- bus_monitor/bus_condition_detector.sv
// Purely combinational; assumes scl and sda never change in the same synchronized cycle
`timescale 1ns/1ps
`default_nettype none

module bus_condition_detector
  import i3c_bus_pkg::*;
(
  input  bus_sample_t bus_i,
  output bus_event_t  event_o
);

  // sda moving while scl is held high marks a bus condition
  logic scl_high;

  assign scl_high = bus_i.scl;

  // START and repeated START look the same on the wires
  assign event_o.start = bus_i.sda_fall & scl_high;

  // STOP releases the bus
  assign event_o.stop = bus_i.sda_rise & scl_high;

  // The phy reports one sda edge at most per cycle,
  // so START and STOP can never coincide
  always_comb begin
    assert final (!(event_o.start && event_o.stop))
      else $error("bus_condition_detector: start and stop high together");
  end

  // Notes for the consumer:
  //  - The strobes follow the phy edge flags, one cycle wide
  //  - A data bit that changes while scl is low is
  //    ordinary data and raises neither strobe
  //  - A STOP with no START before it is still reported

endmodule

`default_nettype wire

//--- bus_monitor/bit_shifter.sv
// Counts every scl rise as a frame bit; the 9th (ACK/T) bit is skipped and never acknowledged
`timescale 1ns/1ps
`default_nettype none

`include "i3c_cfg.svh"

module bit_shifter
  import i3c_bus_pkg::*;
  import i3c_frame_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  bus_sample_t bus_i,
  input  bus_event_t  event_i,
  output logic        byte_valid_o,
  output rx_byte_u    byte_o
);

  localparam int unsigned cnt_w = $clog2(`I3C_BITS_PER_FRAME);
  localparam logic [cnt_w-1:0] last_data_bit = cnt_w'(`I3C_BYTE_BITS - 1);
  localparam logic [cnt_w-1:0] ack_bit = cnt_w'(`I3C_BITS_PER_FRAME - 1);

  logic [cnt_w-1:0]          bit_cnt;
  logic [`I3C_BYTE_BITS-1:0] shift_q;
  logic [`I3C_BYTE_BITS-1:0] shift_next;
  logic                      bus_cond;
  logic                      data_bit;
  logic                      byte_done;

  // MSB arrives first
  assign shift_next = {shift_q[`I3C_BYTE_BITS-2:0], bus_i.sda};

  assign bus_cond  = event_i.start | event_i.stop;
  assign data_bit  = bus_i.scl_rise & (bit_cnt != ack_bit) & ~bus_cond;
  assign byte_done = data_bit & (bit_cnt == last_data_bit);

  // Frame bit counter, modulo 9
  // A bus condition realigns it so a repeated START mid-byte starts clean
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bit_cnt      <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= byte_done;
      if (bus_cond) begin
        bit_cnt <= '0;
      end else if (bus_i.scl_rise) begin
        if (bit_cnt == ack_bit) begin
          bit_cnt <= '0;
        end else begin
          bit_cnt <= bit_cnt + cnt_w'(1);
        end
      end
    end
  end

  // Shift register and output byte
  always_ff @(posedge clk_i) begin
    if (data_bit) begin
      shift_q <= shift_next;
    end
    if (byte_done) begin
      byte_o.raw <= shift_next;
    end
  end

  // A START needs scl high for a full phase after the 8th rise,
  // so it can never meet the byte strobe
  assert property (@(posedge clk_i) disable iff (reset_i)
    event_i.start |-> !byte_valid_o)
    else $error("bit_shifter: byte strobe in the same cycle as START");

endmodule

`default_nettype wire

//--- bus_monitor/frame_decoder.sv
// Strobes carry no back-pressure; a byte seen before any START, or after STOP, is dropped
`timescale 1ns/1ps
`default_nettype none

`include "i3c_cfg.svh"

module frame_decoder
  import i3c_bus_pkg::*;
  import i3c_frame_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  bus_event_t                event_i,
  input  logic                      byte_valid_i,
  input  rx_byte_u                  byte_i,
  output rx_addr_t                  bus_addr_o,
  output logic                      bus_addr_valid_o,
  output logic [`I3C_BYTE_BITS-1:0] rx_data_o,
  output logic                      rx_data_valid_o
);

  frame_state_e state_q;
  frame_state_e state_next;
  logic         addr_take;
  logic         data_take;

  assign addr_take = byte_valid_i & (state_q == ADDR);
  assign data_take = byte_valid_i & (state_q == DATA);

  // Next state
  always_comb begin
    state_next = state_q;
    case (state_q)
      ADDR: begin
        if (byte_valid_i) begin
          state_next = DATA;
        end
      end
      DATA: begin
        state_next = DATA;
      end
      default: begin
        state_next = IDLE;
      end
    endcase

    // Bus conditions win from any state
    if (event_i.stop) begin
      state_next = IDLE;
    end
    if (event_i.start) begin
      state_next = ADDR;
    end
  end

  // State and strobes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q          <= IDLE;
      bus_addr_valid_o <= 1'b0;
      rx_data_valid_o  <= 1'b0;
    end else begin
      state_q          <= state_next;
      bus_addr_valid_o <= addr_take;
      rx_data_valid_o  <= data_take;
    end
  end

  // First byte read as address + RnW, later ones raw
  always_ff @(posedge clk_i) begin
    if (addr_take) begin
      bus_addr_o <= byte_i.addr;
    end
    if (data_take) begin
      rx_data_o <= byte_i.raw;
    end
  end

  // STOP only comes after a whole frame, never with its byte
  assert property (@(posedge clk_i) disable iff (reset_i)
    byte_valid_i |-> !event_i.stop)
    else $error("frame_decoder: byte strobe in the same cycle as STOP");

endmodule

`default_nettype wire

//--- design/i3c_bus_monitor.sv
// Passive I3C receive monitor; never drives scl/sda and never ACKs, results are 1-cycle strobes
`timescale 1ns/1ps
`default_nettype none

`include "i3c_cfg.svh"

module i3c_bus_monitor
  import i3c_bus_pkg::*;
  import i3c_frame_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      scl_i,
  input  logic                      sda_i,
  output logic                      bus_start_o,
  output logic                      bus_stop_o,
  output rx_addr_t                  bus_addr_o,
  output logic                      bus_addr_valid_o,
  output logic [`I3C_BYTE_BITS-1:0] rx_data_o,
  output logic                      rx_data_valid_o
);

  bus_sample_t bus_sample;
  bus_event_t  bus_event;
  logic        byte_valid;
  rx_byte_u    rx_byte;

  i3c_phy xphy (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .bus_o  (bus_sample)
  );

  bus_condition_detector xdetector (
    .bus_i  (bus_sample),
    .event_o(bus_event)
  );

  // Start/stop also realign the bit count
  bit_shifter xshifter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus_i       (bus_sample),
    .event_i     (bus_event),
    .byte_valid_o(byte_valid),
    .byte_o      (rx_byte)
  );

  frame_decoder xdecoder (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .event_i         (bus_event),
    .byte_valid_i    (byte_valid),
    .byte_i          (rx_byte),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .rx_data_o       (rx_data_o),
    .rx_data_valid_o (rx_data_valid_o)
  );

  assign bus_start_o = bus_event.start;
  assign bus_stop_o  = bus_event.stop;

endmodule

`default_nettype wire

//--- tests/tb_i3c_bus_monitor.sv
// Drives scl/sda as a bus controller from falling clk_i edges; every bus task must start on one
`timescale 1ns/1ps
`default_nettype none

`include "i3c_cfg.svh"

module tb_i3c_bus_monitor
  import i3c_frame_pkg::*;
();

  localparam int phase_cycles = 6;
  localparam int bit_cycles = 2 * phase_cycles;
  localparam int cond_cycles = 4 * phase_cycles;
  localparam int drain_limit = 40;
  // Frames, loose bits, conditions and STARTs of all tests together
  localparam int total_bits = 25 * `I3C_BITS_PER_FRAME + 21;
  localparam int total_conds = 16;
  localparam int total_starts = 9;
  localparam int timeout_cycles = 2 * (total_bits * bit_cycles + total_conds * cond_cycles
                                       + total_starts * (`I3C_SYNC_STAGES + 2));

  logic                      clk_i = 1'b0;
  logic                      reset_i;
  logic                      scl_i;
  logic                      sda_i;
  logic                      bus_start_o;
  logic                      bus_stop_o;
  rx_addr_t                  bus_addr_o;
  logic                      bus_addr_valid_o;
  logic [`I3C_BYTE_BITS-1:0] rx_data_o;
  logic                      rx_data_valid_o;

  // Scoreboard of what the controller sent
  rx_addr_t                  exp_addr_q[$];
  logic [`I3C_BYTE_BITS-1:0] exp_data_q[$];
  rx_addr_t                  exp_addr;
  logic [`I3C_BYTE_BITS-1:0] exp_data;
  int exp_starts = 0;
  int exp_stops = 0;
  int starts_seen = 0;
  int stops_seen = 0;
  int error_count = 0;
  int errors_at_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_count = 0;
  logic quiet = 1'b0;
  logic awaiting_addr = 1'b0;
  logic [31:0] rng_state = 32'd29;
  logic [31:0] rnd;

  i3c_bus_monitor uut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .bus_start_o     (bus_start_o),
    .bus_stop_o      (bus_stop_o),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .rx_data_o       (rx_data_o),
    .rx_data_valid_o (rx_data_valid_o)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic pick_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  task automatic note_failure(input string text);
    error_count++;
    $display("failure at %0t ns: %s", $time, text);
  endtask

  task automatic note_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    error_count++;
    $display("error: time %0t ns, signal %s, expected 'h%0h, actual 'h%0h",
             $time, name, expected, actual);
  endtask

  function automatic bit drained();
    return exp_addr_q.size() == 0 && exp_data_q.size() == 0 &&
           starts_seen == exp_starts && stops_seen == exp_stops;
  endfunction

  // Outputs only move on rising edges, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (!(quiet && (bus_start_o || bus_stop_o || bus_addr_valid_o || rx_data_valid_o)))
        else note_failure("a strobe fired while no transfer was open");
      if (bus_start_o) begin
        starts_seen++;
        assert (!awaiting_addr)
          else note_failure("a second START pulse came before the address byte");
        awaiting_addr = 1'b1;
      end
      if (bus_stop_o) begin
        stops_seen++;
        assert (!awaiting_addr)
          else note_failure("a STOP pulse came between a START and its address byte");
      end
      if (bus_addr_valid_o) begin
        assert (awaiting_addr) else note_failure("an address strobe came without a START");
        assert (exp_addr_q.size() > 0) else note_failure("an address strobe came unsent");
        if (exp_addr_q.size() > 0) begin
          exp_addr = exp_addr_q.pop_front();
          assert (bus_addr_o.addr == exp_addr.addr)
            else note_mismatch("bus_addr_o.addr", exp_addr.addr, bus_addr_o.addr);
          assert (bus_addr_o.rnw == exp_addr.rnw)
            else note_mismatch("bus_addr_o.rnw", exp_addr.rnw, bus_addr_o.rnw);
        end
        awaiting_addr = 1'b0;
      end
      if (rx_data_valid_o) begin
        assert (exp_data_q.size() > 0) else note_failure("a data strobe came with no byte sent");
        if (exp_data_q.size() > 0) begin
          exp_data = exp_data_q.pop_front();
          assert (rx_data_o == exp_data) else note_mismatch("rx_data_o", exp_data, rx_data_o);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // From an idle bus, leaves scl low
  task automatic drive_start();
    exp_starts++;
    sda_i = 1'b0;
    wait_cycles(phase_cycles);
    scl_i = 1'b0;
  endtask

  // sda only moves mid low phase
  task automatic drive_bit(input logic b);
    wait_cycles(phase_cycles / 2);
    sda_i = b;
    wait_cycles(phase_cycles - phase_cycles / 2);
    scl_i = 1'b1;
    wait_cycles(phase_cycles);
    scl_i = 1'b0;
  endtask

  task automatic drive_repeated_start();
    drive_bit(1'b1);
    exp_starts++;
    scl_i = 1'b1;
    sda_i = 1'b0;
    wait_cycles(phase_cycles);
    scl_i = 1'b0;
  endtask

  // Leaves both wires released
  task automatic drive_stop();
    wait_cycles(phase_cycles / 2);
    sda_i = 1'b0;
    wait_cycles(phase_cycles - phase_cycles / 2);
    scl_i = 1'b1;
    wait_cycles(phase_cycles);
    exp_stops++;
    sda_i = 1'b1;
    wait_cycles(phase_cycles);
  endtask

  // ACK bit left released
  task automatic send_frame(input logic [7:0] value);
    for (int i = 7; i >= 0; i--) begin
      drive_bit(value[i]);
    end
    drive_bit(1'b1);
  endtask

  task automatic send_address(input logic [6:0] addr, input logic rnw);
    exp_addr_q.push_back('{addr: addr, rnw: rnw});
    send_frame({addr, rnw});
  endtask

  task automatic send_data(input logic [7:0] value);
    exp_data_q.push_back(value);
    send_frame(value);
  endtask

  // scl toggling with no START, ends idle
  task automatic clock_stray_bits(input int n);
    // Low phase first so sda never moves under a high scl
    scl_i = 1'b0;
    for (int i = 0; i < n; i++) begin
      pick_random(rnd);
      drive_bit(rnd[0]);
    end
    wait_cycles(phase_cycles / 2);
    sda_i = 1'b1;
    wait_cycles(phase_cycles - phase_cycles / 2);
    scl_i = 1'b1;
    wait_cycles(phase_cycles);
  endtask

  task automatic end_test(input string name);
    int waited;
    waited = 0;
    while (!drained() && waited < drain_limit) begin
      wait_cycles(1);
      waited++;
    end
    assert (drained())
      else note_failure($sformatf("%0d addresses, %0d data bytes, %0d START, %0d STOP missing",
                                  exp_addr_q.size(), exp_data_q.size(),
                                  exp_starts - starts_seen, exp_stops - stops_seen));
    if (error_count == errors_at_start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  initial begin
    reset_i = 1'b1;
    scl_i = 1'b1;
    sda_i = 1'b1;
    wait_cycles(4);
    reset_i = 1'b0;

    quiet = 1'b1;
    wait_cycles(4 * phase_cycles);
    quiet = 1'b0;
    end_test("idle bus after reset");

    pick_random(rnd);
    drive_start();
    send_address(rnd[6:0], 1'b0);
    for (int d = 0; d < 3; d++) begin
      pick_random(rnd);
      send_data(rnd[7:0]);
    end
    drive_stop();
    end_test("single write transfer");

    for (int t = 0; t < 4; t++) begin
      pick_random(rnd);
      drive_start();
      send_address(rnd[6:0], rnd[7]);
      for (int d = 0; d < 2; d++) begin
        pick_random(rnd);
        send_data(rnd[7:0]);
      end
      drive_stop();
    end
    end_test("random transfers");

    // Repeated START after a 3-bit partial frame, then after a full frame
    pick_random(rnd);
    drive_start();
    send_address(rnd[6:0], rnd[7]);
    send_data(rnd[15:8]);
    send_data(rnd[23:16]);
    drive_bit(rnd[24]);
    drive_bit(rnd[25]);
    drive_bit(rnd[26]);
    drive_repeated_start();
    pick_random(rnd);
    send_address(rnd[6:0], rnd[7]);
    send_data(rnd[15:8]);
    drive_repeated_start();
    send_address(rnd[22:16], rnd[23]);
    send_data(rnd[31:24]);
    drive_stop();
    end_test("repeated start");

    pick_random(rnd);
    drive_start();
    send_address(rnd[6:0], rnd[7]);
    send_data(rnd[15:8]);
    drive_stop();
    quiet = 1'b1;
    clock_stray_bits(2 * `I3C_BITS_PER_FRAME);
    quiet = 1'b0;
    end_test("stop then stray clocks");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/i3c_bus_pkg.sv
common/i3c_frame_pkg.sv
design/i3c_phy.sv
bus_monitor/bus_condition_detector.sv
bus_monitor/bit_shifter.sv
bus_monitor/frame_decoder.sv
design/i3c_bus_monitor.sv
tests/tb_i3c_bus_monitor.sv

//--- Bender.yml
package:
  name: i3c_bus_monitor

sources:
  - include_dirs:
      - common
    files:
      - common/i3c_bus_pkg.sv
      - common/i3c_frame_pkg.sv
      - design/i3c_phy.sv
      - bus_monitor/bus_condition_detector.sv
      - bus_monitor/bit_shifter.sv
      - bus_monitor/frame_decoder.sv
      - design/i3c_bus_monitor.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_i3c_bus_monitor.sv
